//--- hw/isaPkg.sv
`default_nettype none

package isaPkg;

  // Opcodes in register form
  // Setting bit IMM_BIT selects the immediate form
  localparam int IMM_BIT = 3;

  localparam logic [5:0] OPC_ADD  = 6'b000000;
  localparam logic [5:0] OPC_RSUB = 6'b000001;
  localparam logic [5:0] OPC_OR   = 6'b100000;
  localparam logic [5:0] OPC_AND  = 6'b100001;
  localparam logic [5:0] OPC_XOR  = 6'b100010;
  localparam logic [5:0] OPC_LW   = 6'b110010;
  localparam logic [5:0] OPC_SW   = 6'b110110;
  localparam logic [5:0] OPC_BRI  = 6'b100110; // Legal only with the immediate bit set

  // Register operand view
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [10:0] alt;
  } typeAT;

  // Immediate operand view
  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] imm;
  } typeBT;

  typedef union packed {
    typeAT typeA;
    typeBT typeB;
  } instrWordT;

endpackage

`default_nettype wire

//--- hw/corePkg.sv
`default_nettype none

package corePkg;

  // ALU_PASS forwards operand b and marks a branch in execute
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_RSUB,
    ALU_OR,
    ALU_AND,
    ALU_XOR,
    ALU_PASS
  } aluOpT;

  typedef enum logic [1:0] {
    MEM_NONE,
    MEM_LOAD,
    MEM_STORE
  } memOpT;

endpackage

`default_nettype wire

//--- hw/decodeIf.sv
`timescale 1ns/1ns
`default_nettype none

interface decodeIf;

  corePkg::aluOpT aluOp;
  corePkg::memOpT memOp;
  logic           useImm;  // Operand b from simm
  logic [31:0]    simm;
  logic [4:0]     rd;      // Destination, or store source
  logic [4:0]     ra;
  logic [4:0]     rb;
  logic           writeEn;
  logic           valid;

  modport producer (output aluOp, memOp, useImm, simm, rd, ra, rb, writeEn, valid);

  modport consumer (input aluOp, memOp, useImm, simm, rd, ra, rb, writeEn, valid);

  // Register file address lookup
  modport reader (input ra, rb, rd);

endinterface

`default_nettype wire

//--- hw/coreEnable.sv
`timescale 1ns/1ns
`default_nettype none

module coreEnable (
  input  logic sys_clk_i,
  input  logic arstN_i,
  input  logic icacheBusy_i,
  input  logic dcacheBusy_i,
  input  logic memWait_i,
  output logic cpuEnable_o,
  output logic icacheEn_o,
  output logic dcacheReq_o
);

  logic anyBusy;
  logic loadInFlight;  // Load accepted in the previous cycle

  assign anyBusy = icacheBusy_i | dcacheBusy_i;

  // Whole pipeline advances together
  assign cpuEnable_o = ~anyBusy & ~memWait_i;

  // Fetch address only goes out when the pipeline moves
  assign icacheEn_o = cpuEnable_o;

  // Data access allowed when both caches are free and no load is pending
  assign dcacheReq_o = ~anyBusy & ~loadInFlight;

  always_ff @(posedge sys_clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      loadInFlight <= 1'b0;
    end else begin
      loadInFlight <= memWait_i & dcacheReq_o;
    end
  end

endmodule

`default_nettype wire

//--- hw/instFetch.sv
`timescale 1ns/1ns
`default_nettype none

module instFetch #(
  parameter int IW = 32
) (
  input  logic          sys_clk_i,
  input  logic          arstN_i,
  input  logic          enable_i,
  input  logic          branchTaken_i,
  input  logic [31:0]   branchTarget_i,
  output logic [IW-1:0] icacheAddr_o,
  output logic          flush_o
);

  logic [IW-1:0] pc;
  logic          primed;  // First fetch has gone out

  // Taken branch redirects this very cycle, so only one slot is lost
  assign icacheAddr_o = branchTaken_i ? branchTarget_i[IW-1:0] : pc;

  // Word in flight behind a branch is dropped in decode
  // The first enabled cycle has no fetched word yet
  assign flush_o = branchTaken_i | ~primed;

  always_ff @(posedge sys_clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      pc     <= '0;
      primed <= 1'b0;
    end else if (enable_i) begin
      pc     <= icacheAddr_o + IW'(4);
      primed <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- hw/decodeUnit.sv
`timescale 1ns/1ns
`default_nettype none

module decodeUnit (
  input  logic        sys_clk_i,
  input  logic        arstN_i,
  input  logic        enable_i,
  input  logic        flush_i,
  input  logic [31:0] icacheData_i,
  decodeIf.producer   dec
);

  isaPkg::instrWordT word;
  logic              wordValid;
  logic              isImm;
  logic [5:0]        opcBase;  // Opcode with the immediate bit cleared
  logic              legal;

  always_ff @(posedge sys_clk_i) begin
    if (enable_i) begin
      word <= icacheData_i;
    end
  end

  always_ff @(posedge sys_clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      wordValid <= 1'b0;
    end else if (enable_i) begin
      wordValid <= ~flush_i;
    end
  end

  assign isImm   = word.typeA.opcode[isaPkg::IMM_BIT];
  assign opcBase = word.typeA.opcode & ~(6'd1 << isaPkg::IMM_BIT);

  assign dec.rd     = word.typeA.rd;
  assign dec.ra     = word.typeA.ra;
  assign dec.rb     = isImm ? 5'd0 : word.typeA.rb;
  assign dec.useImm = isImm;
  assign dec.simm   = isImm ? {{16{word.typeB.imm[15]}}, word.typeB.imm} : 32'd0;

  always_comb begin
    dec.aluOp   = corePkg::ALU_ADD;
    dec.memOp   = corePkg::MEM_NONE;
    dec.writeEn = 1'b0;
    legal       = 1'b1;
    case (opcBase)
      isaPkg::OPC_ADD:  dec.writeEn = 1'b1;
      isaPkg::OPC_RSUB: begin
        dec.aluOp   = corePkg::ALU_RSUB;
        dec.writeEn = 1'b1;
      end
      isaPkg::OPC_OR: begin
        dec.aluOp   = corePkg::ALU_OR;
        dec.writeEn = 1'b1;
      end
      isaPkg::OPC_AND: begin
        dec.aluOp   = corePkg::ALU_AND;
        dec.writeEn = 1'b1;
      end
      isaPkg::OPC_XOR: begin
        dec.aluOp   = corePkg::ALU_XOR;
        dec.writeEn = 1'b1;
      end
      isaPkg::OPC_LW: begin
        dec.memOp   = corePkg::MEM_LOAD;  // Address from the adder
        dec.writeEn = 1'b1;
      end
      isaPkg::OPC_SW:  dec.memOp = corePkg::MEM_STORE;
      isaPkg::OPC_BRI: begin
        dec.aluOp = corePkg::ALU_PASS;
        legal     = isImm;  // Register branch not supported
      end
      default: legal = 1'b0;
    endcase
    // Extended register forms are outside the subset
    if (!isImm && word.typeA.alt != 11'd0) begin
      legal = 1'b0;
    end
    dec.valid = wordValid & legal;
  end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
  input  logic        sys_clk_i,
  input  logic        arstN_i,
  input  logic        we_i,
  input  logic [4:0]  wAddr_i,
  input  logic [31:0] wData_i,
  decodeIf.reader     dec,
  output logic [31:0] rdA_o,
  output logic [31:0] rdB_o,
  output logic [31:0] rdD_o
);

  logic [31:0] regs [32];

  always_ff @(posedge sys_clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= 32'd0;
      end
    end else if (we_i && wAddr_i != 5'd0) begin
      regs[wAddr_i] <= wData_i;
    end
  end

  // r0 reads as zero whatever the array holds
  assign rdA_o = (dec.ra == 5'd0) ? 32'd0 : regs[dec.ra];
  assign rdB_o = (dec.rb == 5'd0) ? 32'd0 : regs[dec.rb];
  assign rdD_o = (dec.rd == 5'd0) ? 32'd0 : regs[dec.rd];  // Store source

endmodule

`default_nettype wire

//--- hw/execUnit.sv
`timescale 1ns/1ns
`default_nettype none

module execUnit #(
  parameter int DW = 32
) (
  input  logic          sys_clk_i,
  input  logic          arstN_i,
  input  logic          enable_i,
  input  logic [31:0]   rdA_i,
  input  logic [31:0]   rdB_i,
  input  logic [31:0]   rdD_i,
  input  logic [31:0]   dcacheData_i,
  input  logic          dcacheReq_i,
  decodeIf.consumer     dec,
  output logic          we_o,
  output logic [4:0]    wAddr_o,
  output logic [31:0]   wData_o,
  output logic          branchTaken_o,
  output logic [31:0]   branchTarget_o,
  output logic          memWait_o,
  output logic [DW-1:0] dcacheAddr_o,
  output logic [31:0]   dcacheData_o,
  output logic          dcacheEn_o,
  output logic          dcacheWe_o
);

  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] opD;
  logic [31:0] aluRes;
  logic [31:0] xPc;       // PC of the slot now in execute
  logic        isLoad;
  logic        isStore;
  logic        loadPhase; // Load address accepted and data arriving

  // Pending write-back result overrides the register file
  assign opA = (we_o && wAddr_o == dec.ra) ? wData_o : rdA_i;
  assign opB = dec.useImm ? dec.simm : ((we_o && wAddr_o == dec.rb) ? wData_o : rdB_i);
  assign opD = (we_o && wAddr_o == dec.rd) ? wData_o : rdD_i;

  always_comb begin
    case (dec.aluOp)
      corePkg::ALU_ADD:  aluRes = opA + opB;
      corePkg::ALU_RSUB: aluRes = opB - opA;
      corePkg::ALU_OR:   aluRes = opA | opB;
      corePkg::ALU_AND:  aluRes = opA & opB;
      corePkg::ALU_XOR:  aluRes = opA ^ opB;
      default:           aluRes = opB;
    endcase
  end

  assign isLoad  = dec.valid && dec.memOp == corePkg::MEM_LOAD;
  assign isStore = dec.valid && dec.memOp == corePkg::MEM_STORE;

  assign memWait_o    = isLoad & ~loadPhase;
  assign dcacheAddr_o = aluRes[DW-1:0];  // ra plus rb or immediate
  assign dcacheData_o = opD;
  assign dcacheEn_o   = dcacheReq_i & (isStore | memWait_o);
  assign dcacheWe_o   = dcacheReq_i & isStore;

  assign branchTaken_o  = dec.valid && dec.aluOp == corePkg::ALU_PASS;
  assign branchTarget_o = xPc + dec.simm;

  always_ff @(posedge sys_clk_i or negedge arstN_i) begin
    if (!arstN_i) begin
      we_o      <= 1'b0;
      loadPhase <= 1'b0;
      xPc       <= 32'hffff_fff8; // Two empty slots ahead of address 0
    end else begin
      if (memWait_o && dcacheReq_i) begin
        loadPhase <= 1'b1;
      end else if (enable_i) begin
        loadPhase <= 1'b0;
      end
      if (enable_i) begin
        we_o <= dec.valid && dec.writeEn && dec.rd != 5'd0;
        // The flushed slot sits between a branch and its target
        xPc  <= branchTaken_o ? branchTarget_o - 32'd4 : xPc + 32'd4;
      end
    end
  end

  always_ff @(posedge sys_clk_i) begin
    if (enable_i) begin
      wAddr_o <= dec.rd;
      wData_o <= isLoad ? dcacheData_i : aluRes;
    end
  end

endmodule

`default_nettype wire

//--- hw/core32.sv
`timescale 1ns/1ns
`default_nettype none

module core32 #(
  parameter int IW = 32,  // Instruction address width
  parameter int DW = 32   // Data address width
) (
  input  logic          sys_clk_i,
  input  logic          arstN_i,
  input  logic [31:0]   icacheData_i,
  input  logic          icacheBusy_i,
  input  logic [31:0]   dcacheData_i,
  input  logic          dcacheBusy_i,
  output logic [IW-1:0] icacheAddr_o,
  output logic          icacheEn_o,
  output logic [DW-1:0] dcacheAddr_o,
  output logic [31:0]   dcacheData_o,
  output logic          dcacheEn_o,
  output logic          dcacheWe_o
);

  logic        cpuEnable;
  logic        dcacheReq;
  logic        memWait;
  logic        branchTaken;
  logic [31:0] branchTarget;
  logic        flush;
  logic        we;
  logic [4:0]  wAddr;
  logic [31:0] wData;
  logic [31:0] rdA;
  logic [31:0] rdB;
  logic [31:0] rdD;

  decodeIf decIf ();

  coreEnable coreEnable_i (
    .sys_clk_i    (sys_clk_i),
    .arstN_i      (arstN_i),
    .icacheBusy_i (icacheBusy_i),
    .dcacheBusy_i (dcacheBusy_i),
    .memWait_i    (memWait),
    .cpuEnable_o  (cpuEnable),
    .icacheEn_o   (icacheEn_o),
    .dcacheReq_o  (dcacheReq)
  );

  instFetch #(.IW(IW)) instFetch_i (
    .sys_clk_i      (sys_clk_i),
    .arstN_i        (arstN_i),
    .enable_i       (cpuEnable),
    .branchTaken_i  (branchTaken),
    .branchTarget_i (branchTarget),
    .icacheAddr_o   (icacheAddr_o),
    .flush_o        (flush)
  );

  decodeUnit decodeUnit_i (
    .sys_clk_i    (sys_clk_i),
    .arstN_i      (arstN_i),
    .enable_i     (cpuEnable),
    .flush_i      (flush),
    .icacheData_i (icacheData_i),
    .dec          (decIf.producer)
  );

  regFile regFile_i (
    .sys_clk_i (sys_clk_i),
    .arstN_i   (arstN_i),
    .we_i      (we),
    .wAddr_i   (wAddr),
    .wData_i   (wData),
    .dec       (decIf.reader),
    .rdA_o     (rdA),
    .rdB_o     (rdB),
    .rdD_o     (rdD)
  );

  execUnit #(.DW(DW)) execUnit_i (
    .sys_clk_i      (sys_clk_i),
    .arstN_i        (arstN_i),
    .enable_i       (cpuEnable),
    .rdA_i          (rdA),
    .rdB_i          (rdB),
    .rdD_i          (rdD),
    .dcacheData_i   (dcacheData_i),
    .dcacheReq_i    (dcacheReq),
    .dec            (decIf.consumer),
    .we_o           (we),
    .wAddr_o        (wAddr),
    .wData_o        (wData),
    .branchTaken_o  (branchTaken),
    .branchTarget_o (branchTarget),
    .memWait_o      (memWait),
    .dcacheAddr_o   (dcacheAddr_o),
    .dcacheData_o   (dcacheData_o),
    .dcacheEn_o     (dcacheEn_o),
    .dcacheWe_o     (dcacheWe_o)
  );

endmodule

`default_nettype wire

//--- verification/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

localparam int PROG_LEN   = 60;   // Random part of the program
localparam int IMEM_WORDS = 128;
localparam int DMEM_WORDS = 512;
localparam logic [31:0] RESULT_BASE = 32'h0000_0400;  // r1..r31 dumped here at the end

logic [31:0] lfsrState = 32'hc36d_ee07;
logic [31:0] progMem [IMEM_WORDS];
logic [31:0] expAddr [$];  // Expected stores in program order
logic [31:0] expData [$];

// Galois LFSR stepped once per bit taken
function automatic logic [31:0] takeBits(input int n);
  logic [31:0] bits;
  bits = 32'd0;
  for (int i = 0; i < n; i++) begin
    bits      = {bits[30:0], lfsrState[0]};
    lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'h8020_0003 : lfsrState >> 1;
  end
  return bits;
endfunction

// Contents of data memory never written
function automatic logic [31:0] fillWord(input logic [31:0] addr);
  return {addr[15:0], addr[31:16]} ^ (addr * 32'h9e37_79b9);
endfunction

function automatic logic [31:0] encReg(input logic [5:0] opc, input logic [4:0] rd,
                                       input logic [4:0] ra, input logic [4:0] rb);
  return {opc, rd, ra, rb, 11'd0};
endfunction

function automatic logic [31:0] encImm(input logic [5:0] opc, input logic [4:0] rd,
                                       input logic [4:0] ra, input logic [15:0] imm);
  return {opc | (6'd1 << isaPkg::IMM_BIT), rd, ra, imm};
endfunction

function automatic logic [5:0] aluOpcode(input int sel);
  case (sel)
    0:       return isaPkg::OPC_ADD;
    1:       return isaPkg::OPC_RSUB;
    2:       return isaPkg::OPC_OR;
    3:       return isaPkg::OPC_AND;
    default: return isaPkg::OPC_XOR;
  endcase
endfunction

// Mostly r0..r7 so results feed each other
function automatic logic [4:0] pickReg();
  if (takeBits(2) == 32'd0) begin
    return 5'(takeBits(5));
  end
  return 5'(takeBits(3));
endfunction

task automatic buildProgram();
  int          kind;
  int          skip;
  logic [4:0]  rd;
  logic [4:0]  ra;
  logic [4:0]  rb;
  logic [15:0] offs;
  for (int i = 0; i < IMEM_WORDS; i++) begin
    progMem[i] = 32'd0;  // ADD r0 is a no-op
  end
  for (int i = 0; i < PROG_LEN; i++) begin
    kind = int'(takeBits(4));
    rd   = pickReg();
    ra   = pickReg();
    rb   = pickReg();
    offs = 16'(takeBits(6) << 2);  // Word inside the scratch area
    if (kind < 5) begin
      progMem[i] = encReg(aluOpcode(kind), rd, ra, rb);
    end else if (kind < 10) begin
      progMem[i] = encImm(aluOpcode(kind - 5), rd, ra, 16'(takeBits(16)));
    end else if (kind < 14) begin
      // Loads and stores use r0 as base so the register form hits address 0
      if (takeBits(2) == 32'd0) begin
        progMem[i] = encReg(kind < 12 ? isaPkg::OPC_LW : isaPkg::OPC_SW, rd, 5'd0, 5'd0);
      end else begin
        progMem[i] = encImm(kind < 12 ? isaPkg::OPC_LW : isaPkg::OPC_SW, rd, 5'd0, offs);
      end
    end else begin
      skip = int'(takeBits(3)) + 1;
      if (skip > PROG_LEN - i) begin
        skip = PROG_LEN - i;
      end
      progMem[i] = encImm(isaPkg::OPC_BRI, 5'd0, 5'd0, 16'(skip * 4));
    end
  end
  for (int r = 1; r < 32; r++) begin
    progMem[PROG_LEN + r - 1] = encImm(isaPkg::OPC_SW, 5'(r), 5'd0,
                                       16'(RESULT_BASE + 32'(4 * r)));
  end
  progMem[PROG_LEN + 31] = encImm(isaPkg::OPC_BRI, 5'd0, 5'd0, 16'd0);  // Park
endtask

// Sequential instruction-set model stepping one instruction at a time
task automatic runModel();
  logic [31:0] regs [32];
  logic [31:0] mem [DMEM_WORDS];
  logic [31:0] pc;
  logic [31:0] w;
  logic [31:0] opA;
  logic [31:0] opB;
  logic [31:0] simm;
  logic [31:0] addr;
  logic [5:0]  opc;
  logic [4:0]  rd;
  bit          done;
  for (int i = 0; i < 32; i++) begin
    regs[i] = 32'd0;
  end
  for (int i = 0; i < DMEM_WORDS; i++) begin
    mem[i] = fillWord(32'(i * 4));
  end
  pc   = 32'd0;
  done = 1'b0;
  for (int step = 0; step < 4096 && !done; step++) begin
    w    = progMem[pc[8:2]];
    opc  = w[31:26];
    rd   = w[25:21];
    simm = {{16{w[15]}}, w[15:0]};
    opA  = regs[w[20:16]];
    opB  = opc[isaPkg::IMM_BIT] ? simm : regs[w[15:11]];
    addr = opA + opB;
    opc[isaPkg::IMM_BIT] = 1'b0;
    pc   = pc + 32'd4;
    case (opc)
      isaPkg::OPC_ADD:  regs[rd] = opA + opB;
      isaPkg::OPC_RSUB: regs[rd] = opB - opA;
      isaPkg::OPC_OR:   regs[rd] = opA | opB;
      isaPkg::OPC_AND:  regs[rd] = opA & opB;
      isaPkg::OPC_XOR:  regs[rd] = opA ^ opB;
      isaPkg::OPC_LW:   regs[rd] = mem[addr[10:2]];
      isaPkg::OPC_SW: begin
        mem[addr[10:2]] = regs[rd];
        expAddr.push_back(addr);
        expData.push_back(regs[rd]);
      end
      isaPkg::OPC_BRI: begin
        done = (simm == 32'd0);  // Branch to itself
        pc   = pc - 32'd4 + simm;
      end
      default: ;
    endcase
    regs[0] = 32'd0;  // r0 hardwired
  end
endtask

`endif

//--- verification/tbCore.sv
`timescale 1ns/1ns
`default_nettype none

module tbCore;

  `include "tbModel.svh"

  localparam int WAIT_LIMIT = 2000;  // Cycles allowed for each wait

  logic        clk;
  logic        arstN;
  logic [31:0] icacheData;
  logic        icacheBusy;
  logic [31:0] dcacheData;
  logic        dcacheBusy;
  logic [31:0] icacheAddr;
  logic        icacheEn;
  logic [31:0] dcacheAddr;
  logic [31:0] dcacheWdata;
  logic        dcacheEn;
  logic        dcacheWe;
  logic [31:0] dmem [DMEM_WORDS];

  core32 #(
    .IW(32),
    .DW(32)
  ) core32_i (
    .sys_clk_i    (clk),
    .arstN_i      (arstN),
    .icacheData_i (icacheData),
    .icacheBusy_i (icacheBusy),
    .dcacheData_i (dcacheData),
    .dcacheBusy_i (dcacheBusy),
    .icacheAddr_o (icacheAddr),
    .icacheEn_o   (icacheEn),
    .dcacheAddr_o (dcacheAddr),
    .dcacheData_o (dcacheWdata),
    .dcacheEn_o   (dcacheEn),
    .dcacheWe_o   (dcacheWe)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Instruction cache returns data one cycle after accept and holds it otherwise
  always @(posedge clk) begin
    if (icacheEn && !icacheBusy) begin
      icacheData <= (icacheAddr < 32'(4 * IMEM_WORDS)) ? progMem[icacheAddr[8:2]] : 32'd0;
    end
  end

  // Data cache
  always @(posedge clk) begin
    if (dcacheEn && !dcacheBusy) begin
      if (dcacheWe) begin
        dmem[dcacheAddr[10:2]] <= dcacheWdata;
      end else begin
        dcacheData <= dmem[dcacheAddr[10:2]];
      end
    end
  end

  // Random busy on both caches
  always @(posedge clk) begin
    if (!arstN) begin
      icacheBusy <= 1'b0;
      dcacheBusy <= 1'b0;
    end else begin
      icacheBusy <= (takeBits(2) == 32'd3);  // About one cycle in four
      dcacheBusy <= (takeBits(2) == 32'd3);
    end
  end

  task automatic expectEqual(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %08h, expected %08h", $time, what, actual, expected);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", what);
    end
  endtask

  task automatic waitFetch();
    for (int cycles = 0; cycles < WAIT_LIMIT; cycles++) begin
      @(negedge clk);
      if (icacheEn && !icacheBusy) begin
        return;
      end
    end
    $display("No instruction fetch was issued within %0d cycles after reset", WAIT_LIMIT);
    $display("Simulation failed");
    $fatal(1, "Fetch wait timed out");
  endtask

  // Returns in the cycle whose rising edge takes a store
  task automatic waitStore();
    for (int cycles = 0; cycles < WAIT_LIMIT; cycles++) begin
      @(negedge clk);
      if (dcacheEn && dcacheWe && !dcacheBusy) begin
        return;
      end
    end
    $display("No store arrived within %0d cycles", WAIT_LIMIT);
    $display("Simulation failed");
    $fatal(1, "Store wait timed out");
  endtask

  initial begin
    arstN      = 1'b0;
    icacheData = 32'd0;
    icacheBusy = 1'b0;
    dcacheData = 32'd0;
    dcacheBusy = 1'b0;
    buildProgram();
    runModel();
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = fillWord(32'(i * 4));
    end
    repeat (9) @(posedge clk);
    @(negedge clk);
    expectEqual({31'd0, dcacheEn}, 32'd0, "dcache enable in reset");
    expectEqual({31'd0, dcacheWe}, 32'd0, "dcache write enable in reset");
    expectEqual({31'd0, icacheEn}, 32'd1, "icache enable in reset");
    @(posedge clk);
    arstN <= 1'b1;
    waitFetch();
    expectEqual(icacheAddr, 32'd0, "first fetch address");
    for (int n = 0; n < expAddr.size(); n++) begin
      waitStore();
      expectEqual(dcacheAddr, expAddr[n], "store address");
      expectEqual(dcacheWdata, expData[n], "store data");
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verification
hw/isaPkg.sv
hw/corePkg.sv
hw/decodeIf.sv
hw/coreEnable.sv
hw/instFetch.sv
hw/decodeUnit.sv
hw/regFile.sv
hw/execUnit.sv
hw/core32.sv
verification/tbCore.sv

//--- Bender.yml
package:
  name: core32

sources:
  - hw/isaPkg.sv
  - hw/corePkg.sv
  - hw/decodeIf.sv
  - hw/coreEnable.sv
  - hw/instFetch.sv
  - hw/decodeUnit.sv
  - hw/regFile.sv
  - hw/execUnit.sv
  - hw/core32.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tbCore.sv
